// File: source/uart_cfg_pkg.sv
package uart_cfg_pkg;

  // ####################
  // serial link timing.
  // ####################

  // clock cycles per serial bit.
  localparam int BAUD_DIV = 16;
  localparam int HALF_BIT = BAUD_DIV / 2;

  // idle bit times between the address and data frames of a write.
  localparam int FRAME_GAP_BITS = 2;

  // start, data, parity and stop.
  localparam int DATA_BITS  = 8;
  localparam int FRAME_BITS = DATA_BITS + 3;

  typedef logic [DATA_BITS-1:0]         uart_byte_t;
  typedef logic [3:0]                   bit_cnt_t;
  typedef logic [$clog2(BAUD_DIV)-1:0]  baud_cnt_t;

  // bit positions within a frame, start bit is 0.
  localparam bit_cnt_t PARITY_IDX = bit_cnt_t'(DATA_BITS + 1);
  localparam bit_cnt_t STOP_IDX   = bit_cnt_t'(FRAME_BITS - 1);

endpackage

// File: source/reg_cmd_pkg.sv
package reg_cmd_pkg;

  import uart_cfg_pkg::*;

  // ####################
  // host command layout.
  // ####################

  typedef logic [15:0] reg_cmd_t;
  typedef logic [6:0]  reg_addr_t;
  typedef logic [7:0]  reg_data_t;

  // 1 selects a write, 0 a read.
  localparam int WRITE_FLAG_BIT = 15;

  // ####################
  // command engine.
  // ####################

  localparam int REPLY_TIMEOUT_BITS = 24;
  localparam int REPLY_TIMEOUT_CYC  = REPLY_TIMEOUT_BITS * BAUD_DIV;
  localparam int GAP_CYC            = FRAME_GAP_BITS * BAUD_DIV;

  typedef logic [$clog2(REPLY_TIMEOUT_CYC+1)-1:0] eng_timer_t;

  // one cycle to see busy drop, one for the start strobe, one in the transmitter.
  localparam eng_timer_t GAP_LOAD   = eng_timer_t'(GAP_CYC - 3);
  localparam eng_timer_t REPLY_LOAD = eng_timer_t'(REPLY_TIMEOUT_CYC);

  typedef enum logic [2:0] {
    idle,
    send_first,
    gap,
    send_second,
    wait_reply,
    report
  } eng_state_t;

endpackage

// File: source/uart_tx.sv
`timescale 1ns/1ps

module uart_tx
  import uart_cfg_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  uart_byte_t tx_byte,
  input  logic       tx_start,
  output logic       tx,
  output logic       tx_busy
);

  uart_byte_t shift_q;
  logic       parity_q;
  baud_cnt_t  baud_cnt;
  bit_cnt_t   bit_cnt;
  bit_cnt_t   nxt_bit;
  logic       bit_end;
  logic       load;

  assign bit_end = (baud_cnt == baud_cnt_t'(BAUD_DIV - 1));
  assign nxt_bit = bit_cnt + 1'b1;
  assign load    = tx_start && !tx_busy;

  // ####################
  // bit sequencing.
  // ####################

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      tx       <= 1'b1;
      tx_busy  <= 1'b0;
      baud_cnt <= '0;
      bit_cnt  <= '0;
    end
    else if (load)
    begin
      // start bit goes out right away.
      tx       <= 1'b0;
      tx_busy  <= 1'b1;
      baud_cnt <= '0;
      bit_cnt  <= '0;
    end
    else if (tx_busy)
    begin
      if (!bit_end)
      begin
        baud_cnt <= baud_cnt + 1'b1;
      end
      else
      begin
        baud_cnt <= '0;
        bit_cnt  <= nxt_bit;
        if (nxt_bit < PARITY_IDX)
          tx <= shift_q[0];
        else if (nxt_bit == PARITY_IDX)
          tx <= parity_q;
        else
          tx <= 1'b1;
        // stop bit has lasted a full bit time.
        if (bit_cnt == STOP_IDX)
          tx_busy <= 1'b0;
      end
    end
  end

  // data goes out lsb first.
  always_ff @(posedge clk)
  begin
    if (load)
    begin
      shift_q  <= tx_byte;
      parity_q <= ^tx_byte;
    end
    else if (tx_busy && bit_end && nxt_bit < PARITY_IDX)
    begin
      shift_q <= shift_q >> 1;
    end
  end

endmodule

// File: source/uart_rx.sv
`timescale 1ns/1ps

module uart_rx
  import uart_cfg_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       rx,
  output uart_byte_t rx_byte,
  output logic       rx_done,
  output logic       rx_err,
  output logic       rx_active
);

  logic       rx_meta;
  logic       rx_sync;
  logic       rx_prev;
  baud_cnt_t  baud_cnt;
  bit_cnt_t   bit_cnt;
  uart_byte_t shift_q;
  logic       parity_err_q;
  logic       stop_err_q;
  logic       mid_bit;
  logic       bit_end;
  logic       start_edge;
  logic       data_bit;

  assign mid_bit    = (baud_cnt == baud_cnt_t'(HALF_BIT - 1));
  assign bit_end    = (baud_cnt == baud_cnt_t'(BAUD_DIV - 1));
  assign start_edge = rx_prev && !rx_sync;
  assign data_bit   = (bit_cnt != '0) && (bit_cnt < PARITY_IDX);
  assign rx_byte    = shift_q;

  // ####################
  // input synchronizer.
  // ####################

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end
    else
    begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  // ####################
  // frame sampling.
  // ####################

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rx_active    <= 1'b0;
      rx_done      <= 1'b0;
      rx_err       <= 1'b0;
      baud_cnt     <= '0;
      bit_cnt      <= '0;
      parity_err_q <= 1'b0;
      stop_err_q   <= 1'b0;
    end
    else
    begin
      rx_done <= 1'b0;
      if (!rx_active)
      begin
        if (start_edge)
        begin
          rx_active <= 1'b1;
          baud_cnt  <= '0;
          bit_cnt   <= '0;
        end
      end
      else
      begin
        baud_cnt <= bit_end ? '0 : baud_cnt + 1'b1;
        if (bit_end)
          bit_cnt <= bit_cnt + 1'b1;
        if (mid_bit)
        begin
          // line back high at mid start bit, so it was a glitch.
          if (bit_cnt == '0 && rx_sync)
            rx_active <= 1'b0;
          else if (bit_cnt == PARITY_IDX)
            parity_err_q <= rx_sync ^ (^shift_q);
          else if (bit_cnt == STOP_IDX)
            stop_err_q <= !rx_sync;
        end
        if (bit_end && bit_cnt == STOP_IDX)
        begin
          rx_active <= 1'b0;
          rx_done   <= 1'b1;
          rx_err    <= parity_err_q | stop_err_q;
        end
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (rx_active && mid_bit && data_bit)
      shift_q <= {rx_sync, shift_q[DATA_BITS-1:1]};
  end

endmodule

// File: source/reg_cmd_engine.sv
`timescale 1ns/1ps

module reg_cmd_engine
  import uart_cfg_pkg::*;
  import reg_cmd_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  reg_cmd_t   cmd_in,
  input  logic       cmd_vld,
  output logic       cmd_rdy,
  output uart_byte_t tx_byte,
  output logic       tx_start,
  input  logic       tx_busy,
  input  uart_byte_t rx_byte,
  input  logic       rx_done,
  input  logic       rx_err,
  input  logic       rx_active,
  output reg_data_t  read_data,
  output logic       read_rdy,
  output logic       read_err
);

  eng_state_t state_q;
  eng_timer_t timer_q;
  logic       is_write_q;
  reg_data_t  wr_data_q;
  reg_addr_t  cmd_addr;
  logic       cmd_take;
  logic       tx_done;
  logic       gap_over;

  assign cmd_rdy  = (state_q == idle);
  assign cmd_take = cmd_vld && cmd_rdy;
  assign cmd_addr = cmd_in[WRITE_FLAG_BIT-1 -: $bits(reg_addr_t)];

  // busy only rises the cycle after the strobe.
  assign tx_done  = !tx_start && !tx_busy;
  assign gap_over = (state_q == gap) && (timer_q == '0);

  // ####################
  // sequencing FSM.
  // ####################

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q    <= idle;
      timer_q    <= '0;
      is_write_q <= 1'b0;
      tx_start   <= 1'b0;
      read_rdy   <= 1'b0;
      read_err   <= 1'b0;
      read_data  <= '0;
    end
    else
    begin
      tx_start <= 1'b0;
      read_rdy <= 1'b0;
      case (state_q)
        idle:
        begin
          if (cmd_take)
          begin
            is_write_q <= cmd_in[WRITE_FLAG_BIT];
            tx_start   <= 1'b1;
            state_q    <= send_first;
          end
        end
        send_first:
        begin
          if (tx_done)
          begin
            if (is_write_q)
            begin
              timer_q <= GAP_LOAD;
              state_q <= gap;
            end
            else
            begin
              timer_q <= REPLY_LOAD;
              state_q <= wait_reply;
            end
          end
        end
        gap:
        begin
          if (gap_over)
          begin
            tx_start <= 1'b1;
            state_q  <= send_second;
          end
          else
          begin
            timer_q <= timer_q - 1'b1;
          end
        end
        send_second:
        begin
          if (tx_done)
            state_q <= idle;
        end
        wait_reply:
        begin
          if (rx_done)
          begin
            read_data <= rx_byte;
            read_err  <= rx_err;
            state_q   <= report;
          end
          // timer holds while a frame is coming in.
          else if (!rx_active)
          begin
            if (timer_q == '0)
            begin
              read_data <= '0;
              read_err  <= 1'b1;
              state_q   <= report;
            end
            else
            begin
              timer_q <= timer_q - 1'b1;
            end
          end
        end
        report:
        begin
          // strobe lines up with cmd_rdy going high.
          read_rdy <= 1'b1;
          state_q  <= idle;
        end
        default:
        begin
          state_q <= idle;
        end
      endcase
    end
  end

  // address byte carries the write flag in its top bit.
  always_ff @(posedge clk)
  begin
    if (cmd_take)
    begin
      tx_byte   <= {cmd_in[WRITE_FLAG_BIT], cmd_addr};
      wr_data_q <= cmd_in[$bits(reg_data_t)-1:0];
    end
    else if (gap_over)
    begin
      tx_byte <= wr_data_q;
    end
  end

endmodule

// File: source/uart_reg_master.sv
`timescale 1ns/1ps

module uart_reg_master
  import uart_cfg_pkg::*;
  import reg_cmd_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  reg_cmd_t  cmd_in,
  input  logic      cmd_vld,
  output logic      cmd_rdy,
  output logic      tx,
  input  logic      rx,
  output reg_data_t read_data,
  output logic      read_rdy,
  output logic      read_err
);

  uart_byte_t tx_byte;
  logic       tx_start;
  logic       tx_busy;
  uart_byte_t rx_byte;
  logic       rx_done;
  logic       rx_err;
  logic       rx_active;

  reg_cmd_engine engine_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .tx_byte   (tx_byte),
    .tx_start  (tx_start),
    .tx_busy   (tx_busy),
    .rx_byte   (rx_byte),
    .rx_done   (rx_done),
    .rx_err    (rx_err),
    .rx_active (rx_active),
    .read_data (read_data),
    .read_rdy  (read_rdy),
    .read_err  (read_err)
  );

  uart_tx tx_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .tx_byte  (tx_byte),
    .tx_start (tx_start),
    .tx       (tx),
    .tx_busy  (tx_busy)
  );

  // receiver runs freely.
  uart_rx rx_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .rx        (rx),
    .rx_byte   (rx_byte),
    .rx_done   (rx_done),
    .rx_err    (rx_err),
    .rx_active (rx_active)
  );

endmodule

// File: sim/reg_slave_model.sv
`timescale 1ns/1ps

module reg_slave_model
  import uart_cfg_pkg::*;
(
  input  logic clk,
  input  logic rst_n,
  input  logic tx,
  input  logic corrupt_parity,
  input  logic mute,
  output logic rx,
  output logic fmt_err,
  output int   frame_cnt
);

  uart_byte_t regs [128];

  task automatic report(string name, int exp, int act);
    $display("ERR %s expected %0h actual %0h", name, exp, act);
    fmt_err = 1'b1;
  endtask

  // entered just after the start bit was seen low.
  task automatic get_frame(output uart_byte_t data);
    repeat (HALF_BIT) @(posedge clk);
    if (tx)
      report("slave_start_bit", 0, 1);
    for (int i = 0; i < DATA_BITS; i++)
    begin
      repeat (BAUD_DIV) @(posedge clk);
      data[i] = tx;
    end
    repeat (BAUD_DIV) @(posedge clk);
    if (tx != ^data)
      report("slave_parity", int'(^data), int'(tx));
    repeat (BAUD_DIV) @(posedge clk);
    if (!tx)
      report("slave_stop_bit", 1, 0);
    frame_cnt = frame_cnt + 1;
  endtask

  task automatic drive_bit(logic v);
    #1 rx = v;
    repeat (BAUD_DIV) @(posedge clk);
  endtask

  task automatic send_reply(uart_byte_t data);
    repeat (3 * BAUD_DIV - HALF_BIT) @(posedge clk);
    drive_bit(1'b0);
    for (int i = 0; i < DATA_BITS; i++)
      drive_bit(data[i]);
    drive_bit((^data) ^ corrupt_parity);
    drive_bit(1'b1);
  endtask

  // ####################
  // frame decoder.
  // ####################

  initial
  begin
    uart_byte_t addr;
    uart_byte_t data;
    int idle;
    rx = 1'b1;
    fmt_err = 1'b0;
    frame_cnt = 0;
    for (int i = 0; i < 128; i++)
      regs[i] = '0;
    forever
    begin
      @(posedge clk);
      if (rst_n && !tx)
      begin
        get_frame(addr);
        if (addr[7])
        begin
          // idle count starts at the middle of the stop bit.
          idle = 0;
          while (tx && idle < 8 * BAUD_DIV)
          begin
            @(posedge clk);
            idle++;
          end
          if (tx)
            report("slave_data_frame", 1, 0);
          else if (idle < HALF_BIT + FRAME_GAP_BITS * BAUD_DIV)
            report("slave_gap", HALF_BIT + FRAME_GAP_BITS * BAUD_DIV, idle);
          get_frame(data);
          regs[addr[6:0]] = data;
        end
        else if (!mute)
        begin
          send_reply(regs[addr[6:0]]);
        end
      end
    end
  end

endmodule

// File: sim/tb_uart_reg_master.sv
`timescale 1ns/1ps

module tb_uart_reg_master
  import uart_cfg_pkg::*;
  import reg_cmd_pkg::*;
;

  localparam int OP_TIMEOUT = 2000;

  logic      clk;
  logic      rst_n;
  reg_cmd_t  cmd_in;
  logic      cmd_vld;
  logic      cmd_rdy;
  logic      tx;
  logic      rx;
  reg_data_t read_data;
  logic      read_rdy;
  logic      read_err;
  logic      corrupt_parity;
  logic      mute;
  logic      fmt_err;
  int        frame_cnt;

  logic [31:0] lfsr;
  reg_data_t   shadow [128];
  int          op_cycles;

  // expectations for each read in flight.
  string     exp_name_q [$];
  reg_data_t exp_data_q [$];
  logic      exp_err_q  [$];
  logic      exp_chk_q  [$];

  uart_reg_master dut_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .tx        (tx),
    .rx        (rx),
    .read_data (read_data),
    .read_rdy  (read_rdy),
    .read_err  (read_err)
  );

  reg_slave_model slave_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .tx             (tx),
    .corrupt_parity (corrupt_parity),
    .mute           (mute),
    .rx             (rx),
    .fmt_err        (fmt_err),
    .frame_cnt      (frame_cnt)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // ####################
  // helpers.
  // ####################

  task automatic stop_run();
    $display("Errors found");
    $fatal(1, "simulation stopped");
  endtask

  task automatic timeout_fail(string what);
    $display("timeout: %s", what);
    stop_run();
  endtask

  task automatic check_data(string name, reg_data_t exp, reg_data_t act);
    if (exp !== act)
    begin
      $display("ERR %s expected %h actual %h", name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_flag(string name, logic exp, logic act);
    if (exp !== act)
    begin
      $display("ERR %s expected %b actual %b", name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_count(string name, int exp, int act);
    if (exp != act)
    begin
      $display("ERR %s expected %0d actual %0d", name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_at_least(string name, int min_val, int act);
    if (act < min_val)
    begin
      $display("ERR %s expected at least %0d actual %0d", name, min_val, act);
      stop_run();
    end
  endtask

  function automatic logic [31:0] lfsr_step(logic [31:0] s);
    return (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0);
  endfunction

  // one lfsr step per bit taken.
  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++)
    begin
      r = {r[30:0], lfsr[0]};
      lfsr = lfsr_step(lfsr);
    end
    return r;
  endfunction

  function automatic reg_data_t expected_read(reg_addr_t a);
    return shadow[a];
  endfunction

  // mode 0 is a clean reply, 1 a parity error, 2 no reply at all.
  task automatic run_cmd(string name, reg_cmd_t cmd, int mode, bit spurious);
    int        n;
    int        frames_before;
    bit        done;
    reg_addr_t addr;
    addr = cmd[14:8];
    n = 0;
    while (!cmd_rdy)
    begin
      @(posedge clk);
      n++;
      if (n > OP_TIMEOUT)
        timeout_fail("cmd_rdy did not rise before a new command");
    end
    frames_before = frame_cnt;
    if (cmd[WRITE_FLAG_BIT])
    begin
      shadow[addr] = cmd[7:0];
    end
    else
    begin
      exp_name_q.push_back(name);
      exp_data_q.push_back(mode == 0 ? expected_read(addr) : reg_data_t'(0));
      exp_err_q.push_back(mode != 0);
      exp_chk_q.push_back(mode != 1);
    end
    @(posedge clk);
    #1;
    cmd_in  = cmd;
    cmd_vld = 1'b1;
    @(posedge clk);
    #1;
    cmd_vld = 1'b0;
    check_flag({name, "_busy"}, 1'b0, cmd_rdy);
    done = 0;
    n = 0;
    while (!done)
    begin
      @(posedge clk);
      n++;
      if (cmd_rdy)
        done = 1;
      else if (n > OP_TIMEOUT)
        timeout_fail("command did not finish, cmd_rdy stayed low");
      else if (spurious && n == 20)
      begin
        #1;
        cmd_in  = ~cmd;
        cmd_vld = 1'b1;
      end
      else if (spurious && n == 21)
      begin
        #1;
        cmd_vld = 1'b0;
      end
    end
    op_cycles = n;
    if (!cmd[WRITE_FLAG_BIT])
      check_flag({name, "_read_rdy"}, 1'b1, read_rdy);
    check_count({name, "_frames"}, cmd[WRITE_FLAG_BIT] ? 2 : 1, frame_cnt - frames_before);
  endtask

  // ####################
  // compare process.
  // ####################

  always @(posedge clk)
  begin
    if (rst_n && fmt_err)
    begin
      $display("slave model saw a malformed frame on tx");
      stop_run();
    end
    if (rst_n && read_rdy)
    begin
      if (exp_name_q.size() == 0)
      begin
        $display("read_rdy pulsed with no read outstanding");
        stop_run();
      end
      else
      begin
        check_flag({exp_name_q[0], "_err"}, exp_err_q[0], read_err);
        if (exp_chk_q[0])
          check_data(exp_name_q[0], exp_data_q[0], read_data);
        void'(exp_name_q.pop_front());
        void'(exp_data_q.pop_front());
        void'(exp_err_q.pop_front());
        void'(exp_chk_q.pop_front());
      end
    end
  end

  // ####################
  // stimulus.
  // ####################

  initial
  begin
    reg_addr_t a;
    reg_data_t d;
    cmd_in = '0;
    cmd_vld = 1'b0;
    corrupt_parity = 1'b0;
    mute = 1'b0;
    rst_n = 1'b0;
    lfsr = 32'h07db_fba6;
    op_cycles = 0;
    for (int i = 0; i < 128; i++)
      shadow[i] = '0;
    repeat (8) @(posedge clk);
    #1 rst_n = 1'b1;

    // quiet line after reset.
    repeat (40)
    begin
      @(posedge clk);
      check_flag("reset_tx", 1'b1, tx);
      check_flag("reset_cmd_rdy", 1'b1, cmd_rdy);
      check_flag("reset_read_rdy", 1'b0, read_rdy);
    end

    a = reg_addr_t'(rand_bits(7));
    d = reg_data_t'(rand_bits(8));
    run_cmd("write_basic", {1'b1, a, d}, 0, 0);
    run_cmd("read_basic", {1'b0, a, 8'h00}, 0, 0);

    for (int i = 0; i < 40; i++)
    begin
      a = reg_addr_t'(rand_bits(7));
      d = reg_data_t'(rand_bits(8));
      if (rand_bits(1) == 1)
        run_cmd("random_write", {1'b1, a, d}, 0, 0);
      else
        run_cmd("random_read", {1'b0, a, d}, 0, 0);
    end

    #1 corrupt_parity = 1'b1;
    run_cmd("parity_read", {1'b0, a, 8'h00}, 1, 0);
    #1 corrupt_parity = 1'b0;
    run_cmd("parity_recover", {1'b0, a, 8'h00}, 0, 0);

    #1 mute = 1'b1;
    run_cmd("mute_read", {1'b0, a, 8'h00}, 2, 0);
    // error only after the read frame and the whole reply window.
    check_at_least("mute_latency", (FRAME_BITS + REPLY_TIMEOUT_BITS) * BAUD_DIV, op_cycles);
    #1 mute = 1'b0;
    run_cmd("mute_recover", {1'b0, a, 8'h00}, 0, 0);

    a = reg_addr_t'(rand_bits(7));
    d = reg_data_t'(rand_bits(8));
    run_cmd("busy_write", {1'b1, a, d}, 0, 1);
    run_cmd("busy_read", {1'b0, a, 8'h00}, 0, 1);
    run_cmd("busy_check", {1'b0, a, 8'h00}, 0, 0);

    repeat (4 * BAUD_DIV) @(posedge clk);
    check_count("pending_reads", 0, exp_name_q.size());
    $display("No errors");
    $finish;
  end

endmodule

// File: project.f
source/uart_cfg_pkg.sv
source/reg_cmd_pkg.sv
source/uart_tx.sv
source/uart_rx.sv
source/reg_cmd_engine.sv
source/uart_reg_master.sv
sim/reg_slave_model.sv
sim/tb_uart_reg_master.sv

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log.

rm -rf obj_dir build.log sim.log

verilator --binary --timing -j 0 \
  --top-module tb_uart_reg_master \
  -f project.f \
  --Mdir obj_dir -o sim_bin > build.log 2>&1 \
  && ./obj_dir/sim_bin > sim.log 2>&1 \
  || { cat build.log sim.log 2>/dev/null; echo "simulation did not complete"; exit 1; }

cat sim.log

if grep -q "Errors found" sim.log; then
  exit 1
fi
grep -q "No errors" sim.log || exit 1
exit 0
